// File: include/spmm_defines.svh
`ifndef SPMM_DEFINES_SVH
`define SPMM_DEFINES_SVH

// matrix size, also the number of nonzeros per lhs beat
`define SPMM_N 8

// element width, arithmetic wraps at this width
`define SPMM_W 8

// index width and number of adder stages
`define SPMM_LGN ($clog2(`SPMM_N))

// rows carried by one rhs or out beat
`define SPMM_BEAT_ROWS 4

`define SPMM_BEATS (`SPMM_N / `SPMM_BEAT_ROWS)

`endif

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then scan the simulation log
verilator --binary --timing --top-module spmm_tb -f sim.f -o spmm_sim > build.log 2>&1 &&
./obj_dir/spmm_sim > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "no result found in sim.log"; exit 1; }
exit 0

// File: sim.f
+incdir+include
src/spmm_data_pkg.sv
src/spmm_ctrl_pkg.sv
src/spmm_ctrl.sv
src/rhs_loader.sv
src/seg_reduce.sv
src/spmm_pe.sv
src/out_drain.sv
src/spmm_top.sv
tb/spmm_tb.sv

// File: src/out_drain.sv
`include "spmm_defines.svh"

module out_drain (
    input  logic                                    clock,
    input  logic                                    capture,
    input  spmm_data_pkg::elem_vec_t [`SPMM_N-1:0]  pe_rows,
    input  logic                                    drain_go,
    input  spmm_ctrl_pkg::beat_idx_t                drain_beat_idx,
    output spmm_data_pkg::beat_t                    out_beat
);
    import spmm_data_pkg::*;

    // result in row order
    elem_vec_t [`SPMM_N-1:0] result;

    // element j holds column j
    always_ff @(posedge clock) begin
        if (capture) begin
            for (int i = 0; i < `SPMM_N; i++) begin
                for (int j = 0; j < `SPMM_N; j++) begin
                    result[i][j] <= pe_rows[j][i];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (drain_go) begin
            for (int r = 0; r < `SPMM_BEAT_ROWS; r++) begin
                out_beat[r] <= result[int'(drain_beat_idx) * `SPMM_BEAT_ROWS + r];
            end
        end
    end

endmodule

// File: src/rhs_loader.sv
`include "spmm_defines.svh"

module rhs_loader (
    input  logic                                    clock,
    input  logic                                    rhs_we,
    input  spmm_ctrl_pkg::beat_idx_t                rhs_beat_idx,
    input  spmm_data_pkg::beat_t                    rhs_beat,
    output spmm_data_pkg::elem_vec_t [`SPMM_N-1:0]  col_slice
);
    import spmm_data_pkg::*;

    // row major copy of the dense operand
    elem_vec_t [`SPMM_N-1:0] rows;

    always_ff @(posedge clock) begin
        if (rhs_we) begin
            for (int r = 0; r < `SPMM_BEAT_ROWS; r++) begin
                rows[int'(rhs_beat_idx) * `SPMM_BEAT_ROWS + r] <= rhs_beat[r];
            end
        end
    end

    // each element gets its own column
    always_comb begin
        for (int j = 0; j < `SPMM_N; j++) begin
            for (int i = 0; i < `SPMM_N; i++) begin
                col_slice[j][i] = rows[i][j];
            end
        end
    end

endmodule

// File: src/seg_reduce.sv
`include "spmm_defines.svh"

module seg_reduce (
    input  logic                      clock,
    input  spmm_data_pkg::elem_vec_t  products,
    input  spmm_ctrl_pkg::seg_ctrl_t  ctrl,
    output spmm_data_pkg::elem_vec_t  row_sum
);
    import spmm_data_pkg::*;
    import spmm_ctrl_pkg::*;

    elem_vec_t          level [`SPMM_LGN+1];
    seg_ctrl_t          ctrl_lvl [`SPMM_LGN+1];
    elem_vec_t          prefix;
    seg_ctrl_t          fin;
    logic [`SPMM_N-1:0] first_split;
    idx_t               prev_split [`SPMM_N];

    assign level[0] = products;
    assign ctrl_lvl[0] = ctrl;

    // kogge-stone inclusive prefix sum
    for (genvar s = 0; s < `SPMM_LGN; s++) begin : g_stage
        localparam int DIST = 1 << s;
        elem_vec_t sum_q;
        seg_ctrl_t ctrl_q;

        always_ff @(posedge clock) begin
            for (int j = 0; j < `SPMM_N; j++) begin
                if (j >= DIST) begin
                    sum_q[j] <= level[s][j] + level[s][(j + `SPMM_N - DIST) % `SPMM_N];
                end else begin
                    sum_q[j] <= level[s][j];
                end
            end
            ctrl_q <= ctrl_lvl[s];
        end

        assign level[s+1] = sum_q;
        assign ctrl_lvl[s+1] = ctrl_q;
    end

    assign prefix = level[`SPMM_LGN];
    assign fin = ctrl_lvl[`SPMM_LGN];

    // last split strictly before each position
    always_comb begin : split_scan
        logic seen;
        idx_t last;
        seen = 1'b0;
        last = '0;
        for (int j = 0; j < `SPMM_N; j++) begin
            first_split[j] = fin.split[j] && !seen;
            prev_split[j] = last;
            if (fin.split[j]) begin
                seen = 1'b1;
                last = idx_t'(j);
            end
        end
    end

    // segment sum is prefix at end minus prefix at previous split
    always_ff @(posedge clock) begin
        for (int i = 0; i < `SPMM_N; i++) begin
            if (!fin.row_valid[i]) begin
                row_sum[i] <= '0;
            end else if (first_split[fin.out_idx[i]]) begin
                row_sum[i] <= prefix[fin.out_idx[i]];
            end else begin
                row_sum[i] <= prefix[fin.out_idx[i]] - prefix[prev_split[fin.out_idx[i]]];
            end
        end
    end

endmodule

// File: src/spmm_ctrl.sv
`include "spmm_defines.svh"

module spmm_ctrl (
    input  logic                      clock,
    input  logic                      out_start,
    input  logic                      rhs_start,
    input  logic                      lhs_start,
    input  logic                      drain_start,
    output logic                      rhs_ready,
    output logic                      lhs_ready,
    output logic                      out_ready,
    output logic                      rhs_we,
    output spmm_ctrl_pkg::beat_idx_t  rhs_beat_idx,
    output logic                      capture,
    output logic                      drain_go,
    output spmm_ctrl_pkg::beat_idx_t  drain_beat_idx
);
    import spmm_ctrl_pkg::*;

    localparam int LAST_BEAT = `SPMM_BEATS - 1;
    localparam int LATENCY = `SPMM_LGN + 3;
    localparam int CNT_W = $clog2(LATENCY + 1);

    buf_state_t         rhs_state;
    buf_state_t         out_state;
    beat_idx_t          load_cnt;
    beat_idx_t          drain_cnt;
    logic [CNT_W-1:0]   comp_cnt;
    logic               rhs_acc;
    logic               lhs_acc;
    logic               drain_acc;
    logic               draining;

    assign rhs_ready = rhs_state == BUF_FREE;
    assign out_ready = out_state == BUF_FULL;

    assign rhs_acc = rhs_start && rhs_ready;
    assign lhs_acc = lhs_start && lhs_ready;
    assign drain_acc = drain_start && out_ready;

    // out buffer busy with no compute in flight means unloading
    assign draining = out_state == BUF_BUSY && comp_cnt == '0;
    assign capture = comp_cnt == CNT_W'(1);

    // first beat rides with the accepted strobe
    assign rhs_we = rhs_acc || rhs_state == BUF_LOADING;
    assign rhs_beat_idx = (rhs_state == BUF_LOADING) ? load_cnt : '0;
    assign drain_go = drain_acc || draining;
    assign drain_beat_idx = draining ? drain_cnt : '0;

    always_ff @(posedge clock or posedge out_start) begin
        if (out_start) begin
            rhs_state <= BUF_FREE;
            load_cnt <= '0;
        end else begin
            case (rhs_state)
                BUF_FREE: begin
                    if (rhs_acc) begin
                        rhs_state <= (LAST_BEAT == 0) ? BUF_LOADED : BUF_LOADING;
                        load_cnt <= beat_idx_t'(1);
                    end
                end
                BUF_LOADING: begin
                    if (load_cnt == beat_idx_t'(LAST_BEAT)) begin
                        rhs_state <= BUF_LOADED;
                    end
                    load_cnt <= load_cnt + beat_idx_t'(1);
                end
                BUF_LOADED: begin
                    if (lhs_acc) begin
                        rhs_state <= BUF_BUSY;
                    end
                end
                BUF_BUSY: begin
                    if (capture) begin
                        rhs_state <= BUF_FREE;
                    end
                end
                default: rhs_state <= BUF_FREE;
            endcase
        end
    end

    always_ff @(posedge clock or posedge out_start) begin
        if (out_start) begin
            out_state <= BUF_FREE;
            drain_cnt <= '0;
        end else begin
            case (out_state)
                BUF_FREE: begin
                    if (lhs_acc) begin
                        out_state <= BUF_BUSY;
                    end
                end
                BUF_BUSY: begin
                    if (capture) begin
                        out_state <= BUF_FULL;
                    end else if (draining && drain_cnt == beat_idx_t'(LAST_BEAT)) begin
                        out_state <= BUF_FREE;
                    end
                end
                BUF_FULL: begin
                    if (drain_acc) begin
                        out_state <= (LAST_BEAT == 0) ? BUF_FREE : BUF_BUSY;
                    end
                end
                default: out_state <= BUF_FREE;
            endcase
            if (drain_acc) begin
                drain_cnt <= beat_idx_t'(1);
            end else if (draining) begin
                drain_cnt <= drain_cnt + beat_idx_t'(1);
            end
        end
    end

    // countdown to the capture edge
    always_ff @(posedge clock or posedge out_start) begin
        if (out_start) begin
            comp_cnt <= '0;
            lhs_ready <= 1'b0;
        end else begin
            if (lhs_acc) begin
                comp_cnt <= CNT_W'(LATENCY);
            end else if (comp_cnt != '0) begin
                comp_cnt <= comp_cnt - CNT_W'(1);
            end
            if (lhs_acc) begin
                lhs_ready <= 1'b0;
            end else begin
                lhs_ready <= rhs_state == BUF_LOADED && out_state == BUF_FREE;
            end
        end
    end

endmodule

// File: src/spmm_ctrl_pkg.sv
`include "spmm_defines.svh"

package spmm_ctrl_pkg;

    typedef enum logic [2:0] {
        BUF_FREE,
        BUF_LOADING,
        BUF_LOADED,
        BUF_BUSY,
        BUF_FULL
    } buf_state_t;

    // beat number within one matrix transfer
    typedef logic [(`SPMM_BEATS > 1 ? $clog2(`SPMM_BEATS) : 1)-1:0] beat_idx_t;

    // reduction control for one lhs beat
    typedef struct packed {
        logic [`SPMM_N-1:0]                 split;
        logic [`SPMM_N-1:0][`SPMM_LGN-1:0]  out_idx;
        logic [`SPMM_N-1:0]                 row_valid;
    } seg_ctrl_t;

endpackage

// File: src/spmm_data_pkg.sv
`include "spmm_defines.svh"

package spmm_data_pkg;

    typedef logic [`SPMM_W-1:0] elem_t;

    // row or column index
    typedef logic [`SPMM_LGN-1:0] idx_t;

    typedef struct packed {
        idx_t  col;
        elem_t data;
    } nz_entry_t;

    typedef nz_entry_t [`SPMM_N-1:0] nz_vec_t;

    // inclusive end pointer, empty set for a row without nonzeros
    typedef struct packed {
        logic empty;
        idx_t ptr;
    } row_ptr_t;

    typedef row_ptr_t [`SPMM_N-1:0] ptr_vec_t;

    // one row, or one column slice
    typedef elem_t [`SPMM_N-1:0] elem_vec_t;

    typedef elem_vec_t [`SPMM_BEAT_ROWS-1:0] beat_t;

endpackage

// File: src/spmm_pe.sv
`include "spmm_defines.svh"

module spmm_pe (
    input  logic                      clock,
    input  logic                      lhs_start,
    input  spmm_data_pkg::nz_vec_t    lhs_nz,
    input  spmm_data_pkg::ptr_vec_t   lhs_ptr,
    input  spmm_data_pkg::elem_vec_t  col_slice,
    output spmm_data_pkg::elem_vec_t  pe_row
);
    import spmm_data_pkg::*;
    import spmm_ctrl_pkg::*;

    elem_vec_t  products;
    seg_ctrl_t  ctrl_next;
    seg_ctrl_t  ctrl;
    elem_vec_t  row_sum;

    // each row closes its segment at its end pointer
    always_comb begin : seg_decode
        logic seen;
        idx_t last_end;
        seen = 1'b0;
        last_end = '0;
        ctrl_next = '0;
        for (int i = 0; i < `SPMM_N; i++) begin
            if (!lhs_ptr[i].empty) begin
                if (lhs_start && (!seen || lhs_ptr[i].ptr != last_end)) begin
                    ctrl_next.split[lhs_ptr[i].ptr] = 1'b1;
                    ctrl_next.out_idx[i] = lhs_ptr[i].ptr;
                    ctrl_next.row_valid[i] = 1'b1;
                end
                seen = 1'b1;
                last_end = lhs_ptr[i].ptr;
            end
        end
    end

    // gather and multiply, wraps at element width
    always_ff @(posedge clock) begin
        for (int k = 0; k < `SPMM_N; k++) begin
            products[k] <= lhs_nz[k].data * col_slice[lhs_nz[k].col];
        end
        ctrl <= ctrl_next;
    end

    seg_reduce seg_reduce_inst (
        .clock   (clock),
        .products(products),
        .ctrl    (ctrl),
        .row_sum (row_sum)
    );

    // rows without nonzeros come back as zero
    always_ff @(posedge clock) begin
        pe_row <= row_sum;
    end

endmodule

// File: src/spmm_top.sv
`include "spmm_defines.svh"

module spmm_top (
    input  logic                     clock,
    input  logic                     out_start,
    input  logic                     rhs_start,
    input  spmm_data_pkg::beat_t     rhs_beat,
    input  logic                     lhs_start,
    input  spmm_data_pkg::nz_vec_t   lhs_nz,
    input  spmm_data_pkg::ptr_vec_t  lhs_ptr,
    input  logic                     drain_start,
    output logic                     rhs_ready,
    output logic                     lhs_ready,
    output logic                     out_ready,
    output spmm_data_pkg::beat_t     out_beat
);
    import spmm_data_pkg::*;
    import spmm_ctrl_pkg::*;

    logic                     rhs_we;
    beat_idx_t                rhs_beat_idx;
    logic                     capture;
    logic                     drain_go;
    beat_idx_t                drain_beat_idx;
    elem_vec_t [`SPMM_N-1:0]  col_slice;
    elem_vec_t [`SPMM_N-1:0]  pe_rows;

    spmm_ctrl spmm_ctrl_inst (
        .clock         (clock),
        .out_start     (out_start),
        .rhs_start     (rhs_start),
        .lhs_start     (lhs_start),
        .drain_start   (drain_start),
        .rhs_ready     (rhs_ready),
        .lhs_ready     (lhs_ready),
        .out_ready     (out_ready),
        .rhs_we        (rhs_we),
        .rhs_beat_idx  (rhs_beat_idx),
        .capture       (capture),
        .drain_go      (drain_go),
        .drain_beat_idx(drain_beat_idx)
    );

    rhs_loader rhs_loader_inst (
        .clock       (clock),
        .rhs_we      (rhs_we),
        .rhs_beat_idx(rhs_beat_idx),
        .rhs_beat    (rhs_beat),
        .col_slice   (col_slice)
    );

    // one element per output column
    for (genvar j = 0; j < `SPMM_N; j++) begin : g_pe
        spmm_pe spmm_pe_inst (
            .clock    (clock),
            .lhs_start(lhs_start),
            .lhs_nz   (lhs_nz),
            .lhs_ptr  (lhs_ptr),
            .col_slice(col_slice[j]),
            .pe_row   (pe_rows[j])
        );
    end

    out_drain out_drain_inst (
        .clock         (clock),
        .capture       (capture),
        .pe_rows       (pe_rows),
        .drain_go      (drain_go),
        .drain_beat_idx(drain_beat_idx),
        .out_beat      (out_beat)
    );

endmodule

// File: tb/spmm_tb.sv
`include "spmm_defines.svh"

module spmm_tb;
    import spmm_data_pkg::*;

    localparam int N = `SPMM_N;
    localparam int ROWS = `SPMM_BEAT_ROWS;
    localparam int BEATS = `SPMM_BEATS;
    localparam int LATENCY = `SPMM_LGN + 3;
    localparam int PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_CYCLES = 100;
    localparam int NUM_TESTS = 5;
    localparam int MARGIN_CYCLES = 100;
    localparam int WAIT_LIMIT = 40;
    localparam int SEL_RHS = 0;
    localparam int SEL_LHS = 1;
    localparam int SEL_OUT = 2;

    logic     clock;
    logic     out_start;
    logic     rhs_start;
    beat_t    rhs_beat;
    logic     lhs_start;
    nz_vec_t  lhs_nz;
    ptr_vec_t lhs_ptr;
    logic     drain_start;
    logic     rhs_ready;
    logic     lhs_ready;
    logic     out_ready;
    beat_t    out_beat;

    integer seed;
    int     errors;
    int     checks;
    elem_t  rhs_m [N][N];
    elem_t  a_dense [N][N];
    elem_t  expected [N][N];
    elem_t  result [N][N];
    idx_t   nz_col [N];
    elem_t  nz_val [N];
    logic   row_empty [N];
    idx_t   row_end [N];

    spmm_top spmm_top_inst (
        .clock      (clock),
        .out_start  (out_start),
        .rhs_start  (rhs_start),
        .rhs_beat   (rhs_beat),
        .lhs_start  (lhs_start),
        .lhs_nz     (lhs_nz),
        .lhs_ptr    (lhs_ptr),
        .drain_start(drain_start),
        .rhs_ready  (rhs_ready),
        .lhs_ready  (lhs_ready),
        .out_ready  (out_ready),
        .out_beat   (out_beat)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // ends a run that stalls somewhere
    initial begin
        #(PERIOD * (RESET_CYCLES + NUM_TESTS * TEST_CYCLES + MARGIN_CYCLES));
        $display("Error: watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    // inputs change 5 units after the edge, outputs are read there too
    task automatic step();
        @(posedge clock);
        #5;
    endtask

    function automatic logic ready_of(input int sel);
        case (sel)
            SEL_RHS: return rhs_ready;
            SEL_LHS: return lhs_ready;
            default: return out_ready;
        endcase
    endfunction

    task automatic wait_ready(input string test, input int sel);
        int n;
        n = 0;
        while (!ready_of(sel) && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (!ready_of(sel)) begin
            errors++;
            $display("Error: %s ready level %0d never rose", test, sel);
        end
    endtask

    task automatic bit_check(input string test, input string what, input logic exp,
                             input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s %s expected %b actual %b", test, what, exp, act);
        end
    endtask

    task automatic elem_check(input string test, input string what, input elem_t exp,
                              input elem_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s %s expected %h actual %h", test, what, exp, act);
        end
    endtask

    // expand compressed rows, segment starts after previous row end
    task automatic dense_lhs();
        int start;
        start = 0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                a_dense[i][j] = '0;
            end
            if (!row_empty[i]) begin
                for (int k = start; k <= int'(row_end[i]); k++) begin
                    a_dense[i][nz_col[k]] = a_dense[i][nz_col[k]] + nz_val[k];
                end
                start = int'(row_end[i]) + 1;
            end
        end
    endtask

    task automatic dense_product();
        elem_t acc;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                acc = '0;
                for (int k = 0; k < N; k++) begin
                    acc = acc + a_dense[i][k] * rhs_m[k][j];
                end
                expected[i][j] = acc;
            end
        end
    endtask

    // row lengths 0 to 2, unused slots carry junk
    task automatic lhs_random();
        logic [31:0] rnd;
        int used;
        int cnt;
        used = 0;
        for (int k = 0; k < N; k++) begin
            rnd = $random(seed);
            nz_col[k] = rnd[`SPMM_LGN-1:0];
            nz_val[k] = rnd[15:8];
        end
        for (int i = 0; i < N; i++) begin
            rnd = $random(seed);
            cnt = int'(rnd[1:0]) % 3;
            if (cnt > N - used) begin
                cnt = N - used;
            end
            row_empty[i] = (cnt == 0);
            row_end[i] = (cnt == 0) ? rnd[`SPMM_LGN+7:8] : idx_t'(used + cnt - 1);
            used += cnt;
        end
    endtask

    task automatic rhs_random();
        logic [31:0] rnd;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                rnd = $random(seed);
                rhs_m[i][j] = rnd[7:0];
            end
        end
    endtask

    task automatic load_rhs(input string test);
        wait_ready(test, SEL_RHS);
        for (int b = 0; b < BEATS; b++) begin
            rhs_start = (b == 0);
            for (int r = 0; r < ROWS; r++) begin
                for (int j = 0; j < N; j++) begin
                    rhs_beat[r][j] = rhs_m[b * ROWS + r][j];
                end
            end
            step();
            if (b == 0) begin
                bit_check(test, "rhs_ready after load start", 1'b0, rhs_ready);
            end
        end
        rhs_start = 1'b0;
        rhs_beat = '0;
    endtask

    // returns edges from the accepting edge until out_ready
    task automatic start_compute(input string test, output int edges);
        wait_ready(test, SEL_LHS);
        lhs_start = 1'b1;
        for (int k = 0; k < N; k++) begin
            lhs_nz[k].col = nz_col[k];
            lhs_nz[k].data = nz_val[k];
            lhs_ptr[k].empty = row_empty[k];
            lhs_ptr[k].ptr = row_end[k];
        end
        step();
        lhs_start = 1'b0;
        lhs_nz = '0;
        lhs_ptr = '0;
        edges = 0;
        while (!out_ready && edges < WAIT_LIMIT) begin
            step();
            edges++;
        end
        if (!out_ready) begin
            errors++;
            $display("Error: %s result never reached the output buffer", test);
        end
    endtask

    task automatic drain_result(input string test);
        wait_ready(test, SEL_OUT);
        drain_start = 1'b1;
        step();
        drain_start = 1'b0;
        for (int b = 0; b < BEATS; b++) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int j = 0; j < N; j++) begin
                    result[b * ROWS + r][j] = out_beat[r][j];
                end
            end
            step();
        end
        bit_check(test, "out_ready after unload", 1'b0, out_ready);
    endtask

    task automatic result_check(input string test);
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                elem_check(test, $sformatf("c[%0d][%0d]", i, j), expected[i][j],
                           result[i][j]);
            end
        end
    endtask

    task automatic reset_values();
        for (int c = 0; c < 2; c++) begin
            bit_check("reset_values", "rhs_ready", 1'b1, rhs_ready);
            bit_check("reset_values", "lhs_ready", 1'b0, lhs_ready);
            bit_check("reset_values", "out_ready", 1'b0, out_ready);
            step();
        end
    endtask

    // one nonzero per row against an identity rhs
    task automatic identity_product();
        logic [31:0] rnd;
        int edges;
        for (int i = 0; i < N; i++) begin
            rnd = $random(seed);
            nz_col[i] = idx_t'((i * 3 + 1) % N);
            nz_val[i] = rnd[7:0];
            row_empty[i] = 1'b0;
            row_end[i] = idx_t'(i);
            for (int j = 0; j < N; j++) begin
                rhs_m[i][j] = (i == j) ? 8'd1 : 8'd0;
            end
        end
        dense_lhs();
        expected = a_dense;
        load_rhs("identity_product");
        start_compute("identity_product", edges);
        drain_result("identity_product");
        result_check("identity_product");
    endtask

    task automatic random_products();
        int edges;
        for (int round = 0; round < 3; round++) begin
            lhs_random();
            rhs_random();
            dense_lhs();
            dense_product();
            load_rhs("random_products");
            start_compute("random_products", edges);
            checks++;
            if (edges != LATENCY) begin
                errors++;
                $display("Error: random_products latency expected %0d actual %0d",
                         LATENCY, edges);
            end
            drain_result("random_products");
            result_check("random_products");
        end
    endtask

    task automatic ignored_strobes();
        int edges;
        drain_start = 1'b1;
        step();
        drain_start = 1'b0;
        lhs_start = 1'b1;
        step();
        lhs_start = 1'b0;
        // spans a full compute latency
        for (int c = 0; c < LATENCY + 2; c++) begin
            bit_check("ignored_strobes", "rhs_ready", 1'b1, rhs_ready);
            bit_check("ignored_strobes", "lhs_ready", 1'b0, lhs_ready);
            bit_check("ignored_strobes", "out_ready", 1'b0, out_ready);
            // last beat of the previous result stays on the output
            for (int r = 0; r < ROWS; r++) begin
                for (int j = 0; j < N; j++) begin
                    elem_check("ignored_strobes", "held out_beat",
                               expected[(BEATS - 1) * ROWS + r][j], out_beat[r][j]);
                end
            end
            step();
        end
        lhs_random();
        rhs_random();
        dense_lhs();
        dense_product();
        load_rhs("ignored_strobes");
        start_compute("ignored_strobes", edges);
        drain_result("ignored_strobes");
        result_check("ignored_strobes");
    endtask

    // a full output buffer holds off the next compute
    task automatic back_pressure();
        int edges;
        lhs_random();
        rhs_random();
        dense_lhs();
        dense_product();
        load_rhs("back_pressure");
        start_compute("back_pressure", edges);
        rhs_random();
        load_rhs("back_pressure");
        for (int c = 0; c < 6; c++) begin
            bit_check("back_pressure", "lhs_ready while full", 1'b0, lhs_ready);
            step();
        end
        drain_result("back_pressure");
        result_check("back_pressure");
        wait_ready("back_pressure", SEL_LHS);
        lhs_random();
        dense_lhs();
        dense_product();
        start_compute("back_pressure", edges);
        drain_result("back_pressure");
        result_check("back_pressure");
    endtask

    initial begin
        seed = 6;
        errors = 0;
        checks = 0;
        out_start = 1'b1;
        rhs_start = 1'b0;
        rhs_beat = '0;
        lhs_start = 1'b0;
        lhs_nz = '0;
        lhs_ptr = '0;
        drain_start = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #5;
        out_start = 1'b0;
        reset_values();
        identity_product();
        random_products();
        ignored_strobes();
        back_pressure();
        step();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
